// File: rtl/load_issue_pkg.sv
package load_issue_pkg;

    //////////////////////////////////////////////////////////////////////
    // queue geometry
    //////////////////////////////////////////////////////////////////////

    localparam int DIS_PORTS = 2;               // loads offered per cycle
    localparam int BANKS     = 2;               // one issue port per bank
    localparam int BANK_SIZE = 4;
    localparam int SLOT_W    = 2;               // slot index inside a bank
    localparam int CNT_W     = 3;               // occupancy 0..BANK_SIZE
    localparam int BANK_W    = $clog2(BANKS);
    localparam int PORT_W    = $clog2(DIS_PORTS);
    localparam int WB_PORTS  = 2;

    //////////////////////////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////////////////////////

    localparam int PREG_W = 6;
    localparam int ROB_W  = 5;
    localparam int LQ_W   = 4;
    localparam int SQ_W   = 4;
    localparam int IMM_W  = 12;

    typedef struct packed {
        logic             wrap;                 // flips each lap of the rob
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef enum logic {
        reply_replay,                           // pipeline missed, issue again
        reply_done                              // load finished, free the slot
    } reply_kind_e;

    // wakeup and age part of an entry
    typedef struct packed {
        logic              rs1_ready;
        logic [PREG_W-1:0] rs1_preg;
        rob_idx_t          rob;
    } load_status_t;

    // handed to the load pipeline on issue
    typedef struct packed {
        logic [IMM_W-1:0]  imm;
        mem_size_e         size;
        logic              sext;
        logic [PREG_W-1:0] rd;
        logic [LQ_W-1:0]   lq_idx;
        logic [SQ_W-1:0]   sq_idx;
    } load_payload_t;

    typedef struct packed {
        load_status_t  status;
        load_payload_t payload;
    } load_dispatch_t;

    // true when a sits strictly before b in program order;
    // a lower index is older unless the wrap bits differ
    function automatic logic rob_older(rob_idx_t a, rob_idx_t b);
        return (a.wrap ^ b.wrap) ^ (a.idx < b.idx);
    endfunction

endpackage

// File: rtl/load_bank_if.sv
interface load_bank_if;

    //////////////////////////////////////////////////////////////////////
    // allocation path, steering -> bank
    //////////////////////////////////////////////////////////////////////

    logic                           alloc_valid;   // write entry into lowest free slot
    load_issue_pkg::load_dispatch_t alloc_entry;

    //////////////////////////////////////////////////////////////////////
    // occupancy, bank -> steering
    //////////////////////////////////////////////////////////////////////

    logic                              full;
    logic [load_issue_pkg::CNT_W-1:0]  count;      // valid slots this cycle

    modport queue (
        output alloc_valid,
        output alloc_entry,
        input  full,
        input  count
    );

    modport bank (
        input  alloc_valid,
        input  alloc_entry,
        output full,
        output count
    );

endinterface

// File: rtl/load_issue_bank.sv
module load_issue_bank (
    input  logic                                clk,
    input  logic                                rst_n,
    load_bank_if.bank                           io,
    input  logic [load_issue_pkg::WB_PORTS-1:0] wb_valid,
    input  logic [load_issue_pkg::PREG_W-1:0]   wb_preg [load_issue_pkg::WB_PORTS],
    input  logic                                reply_valid,
    input  logic [load_issue_pkg::SLOT_W-1:0]   reply_slot,
    input  load_issue_pkg::reply_kind_e         reply_kind,
    input  logic                                redirect,
    input  load_issue_pkg::rob_idx_t            redirect_rob,
    input  logic                                issue_ready,
    output logic                                issue_valid,
    output load_issue_pkg::load_payload_t       issue_payload,
    output load_issue_pkg::rob_idx_t            issue_rob,
    output logic [load_issue_pkg::SLOT_W-1:0]   issue_slot
);

    logic [load_issue_pkg::BANK_SIZE-1:0] slot_valid;
    logic [load_issue_pkg::BANK_SIZE-1:0] slot_issued;
    load_issue_pkg::load_status_t         slot_status  [load_issue_pkg::BANK_SIZE];
    load_issue_pkg::load_payload_t        slot_payload [load_issue_pkg::BANK_SIZE];

    logic                                 has_free;
    logic [load_issue_pkg::SLOT_W-1:0]    free_idx;
    logic                                 alloc_en;
    logic [load_issue_pkg::CNT_W-1:0]     occ;

    logic [load_issue_pkg::BANK_SIZE-1:0] wake;
    logic [load_issue_pkg::BANK_SIZE-1:0] ready;
    logic                                 sel_found;
    logic [load_issue_pkg::SLOT_W-1:0]    sel_idx;
    logic                                 issue_fire;

    logic [load_issue_pkg::BANK_SIZE-1:0] alloc_mask;
    logic [load_issue_pkg::BANK_SIZE-1:0] done_mask;
    logic [load_issue_pkg::BANK_SIZE-1:0] replay_mask;
    logic [load_issue_pkg::BANK_SIZE-1:0] issue_mask;
    logic [load_issue_pkg::BANK_SIZE-1:0] keep_mask;

    //////////////////////////////////////////////////////////////////////
    // occupancy and free slot
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = load_issue_pkg::BANK_SIZE - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin             // walk down so the lowest wins
                has_free = 1'b1;
                free_idx = i[load_issue_pkg::SLOT_W-1:0];
            end
        end
    end

    always_comb begin
        occ = '0;
        for (int i = 0; i < load_issue_pkg::BANK_SIZE; i++) begin
            occ = occ + {{(load_issue_pkg::CNT_W-1){1'b0}}, slot_valid[i]};
        end
    end

    assign alloc_en = io.alloc_valid & has_free;
    assign io.full  = ~has_free;
    assign io.count = occ;

    //////////////////////////////////////////////////////////////////////
    // wakeup and oldest-ready select
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < load_issue_pkg::BANK_SIZE; i++) begin
            wake[i] = 1'b0;
            for (int j = 0; j < load_issue_pkg::WB_PORTS; j++) begin
                if (wb_valid[j] && wb_preg[j] == slot_status[i].rs1_preg) begin
                    wake[i] = 1'b1;
                end
            end
            ready[i] = slot_valid[i] & slot_status[i].rs1_ready & ~slot_issued[i];
        end
    end

    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < load_issue_pkg::BANK_SIZE; i++) begin
            if (ready[i] && (!sel_found ||
                load_issue_pkg::rob_older(slot_status[i].rob, slot_status[sel_idx].rob))) begin
                sel_found = 1'b1;
                sel_idx   = i[load_issue_pkg::SLOT_W-1:0];
            end
        end
    end

    assign issue_valid   = sel_found & ~redirect;   // no issue while flushing
    assign issue_payload = slot_payload[sel_idx];
    assign issue_rob     = slot_status[sel_idx].rob;
    assign issue_slot    = sel_idx;
    assign issue_fire    = issue_valid & issue_ready;

    //////////////////////////////////////////////////////////////////////
    // per-slot update masks
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < load_issue_pkg::BANK_SIZE; i++) begin
            alloc_mask[i]  = alloc_en && free_idx == i;
            issue_mask[i]  = issue_fire && sel_idx == i;
            done_mask[i]   = reply_valid && reply_slot == i &&
                             reply_kind == load_issue_pkg::reply_done;
            replay_mask[i] = reply_valid && reply_slot == i &&
                             reply_kind == load_issue_pkg::reply_replay;
            // redirect keeps everything not younger than redirect_rob
            keep_mask[i]   = ~redirect |
                             ~load_issue_pkg::rob_older(redirect_rob, slot_status[i].rob);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid  <= '0;
            slot_issued <= '0;
        end else begin
            slot_valid  <= (slot_valid | alloc_mask) & ~done_mask & keep_mask;
            slot_issued <= ((slot_issued & ~alloc_mask) | issue_mask) & ~replay_mask;
        end
    end

    // a wakeup in the allocation cycle is dropped, dispatch status wins
    always_ff @(posedge clk) begin
        for (int i = 0; i < load_issue_pkg::BANK_SIZE; i++) begin
            if (alloc_mask[i]) begin
                slot_status[i]  <= io.alloc_entry.status;
                slot_payload[i] <= io.alloc_entry.payload;
            end else if (wake[i]) begin
                slot_status[i].rs1_ready <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/load_dispatch_steer.sv
module load_dispatch_steer (
    input  logic [load_issue_pkg::DIS_PORTS-1:0] dis_valid,
    input  load_issue_pkg::load_dispatch_t       dis_data [load_issue_pkg::DIS_PORTS],
    input  logic                                 redirect,
    output logic                                 dis_ready,
    load_bank_if.queue                           bank_io [load_issue_pkg::BANKS]
);

    logic [load_issue_pkg::CNT_W-1:0]  cnt        [load_issue_pkg::BANKS];
    logic [load_issue_pkg::BANKS-1:0]  bank_full;
    logic [load_issue_pkg::BANK_W-1:0] rank_pos   [load_issue_pkg::BANKS];
    logic [load_issue_pkg::BANK_W-1:0] ranked     [load_issue_pkg::BANKS];
    logic [load_issue_pkg::BANK_W-1:0] tgt        [load_issue_pkg::DIS_PORTS];
    logic [load_issue_pkg::BANK_W:0]   n_valid;
    logic [load_issue_pkg::BANKS-1:0]  alloc_hit;
    logic [load_issue_pkg::PORT_W-1:0] alloc_port [load_issue_pkg::BANKS];
    logic                              blocked;

    //////////////////////////////////////////////////////////////////////
    // rank banks by occupancy, emptiest first
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
            rank_pos[b] = '0;
            for (int c = 0; c < load_issue_pkg::BANKS; c++) begin
                if (cnt[c] < cnt[b] || (cnt[c] == cnt[b] && c < b)) begin
                    rank_pos[b] = rank_pos[b] + 1'b1;   // c goes ahead of b
                end
            end
        end
        for (int r = 0; r < load_issue_pkg::BANKS; r++) begin
            ranked[r] = '0;
            for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
                if (rank_pos[b] == r) begin
                    ranked[r] = b[load_issue_pkg::BANK_W-1:0];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // k-th valid port goes to k-th ranked bank
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        n_valid = '0;
        blocked = 1'b0;
        for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
            alloc_hit[b]  = 1'b0;
            alloc_port[b] = '0;
        end
        for (int p = 0; p < load_issue_pkg::DIS_PORTS; p++) begin
            tgt[p] = ranked[n_valid[load_issue_pkg::BANK_W-1:0]];
            if (dis_valid[p]) begin
                n_valid             = n_valid + 1'b1;
                alloc_hit[tgt[p]]  = 1'b1;
                alloc_port[tgt[p]] = p[load_issue_pkg::PORT_W-1:0];
                blocked             = blocked | bank_full[tgt[p]];
            end
        end
    end

    assign dis_ready = ~redirect & ~blocked;     // whole group or nothing

    for (genvar b = 0; b < load_issue_pkg::BANKS; b++) begin : g_bank
        assign cnt[b]                 = bank_io[b].count;
        assign bank_full[b]           = bank_io[b].full;
        assign bank_io[b].alloc_valid = alloc_hit[b] & dis_ready;
        assign bank_io[b].alloc_entry = dis_data[alloc_port[b]];
    end

endmodule

// File: rtl/load_issue_queue.sv
module load_issue_queue (
    input  logic                                clk,
    input  logic                                rst_n,

    // dispatch
    input  logic [load_issue_pkg::DIS_PORTS-1:0] dis_valid,
    input  load_issue_pkg::load_dispatch_t       dis_data [load_issue_pkg::DIS_PORTS],
    output logic                                 dis_ready,

    // issue, one port per bank
    output logic [load_issue_pkg::BANKS-1:0]     issue_valid,
    input  logic [load_issue_pkg::BANKS-1:0]     issue_ready,
    output load_issue_pkg::load_payload_t        issue_payload [load_issue_pkg::BANKS],
    output load_issue_pkg::rob_idx_t             issue_rob [load_issue_pkg::BANKS],
    output logic [load_issue_pkg::SLOT_W-1:0]    issue_slot [load_issue_pkg::BANKS],

    // reply from the load pipeline
    input  logic                                 reply_valid,
    input  logic [load_issue_pkg::BANK_W-1:0]    reply_bank,
    input  logic [load_issue_pkg::SLOT_W-1:0]    reply_slot,
    input  load_issue_pkg::reply_kind_e          reply_kind,

    // writeback wakeup
    input  logic [load_issue_pkg::WB_PORTS-1:0]  wb_valid,
    input  logic [load_issue_pkg::PREG_W-1:0]    wb_preg [load_issue_pkg::WB_PORTS],

    // flush
    input  logic                                 redirect,
    input  load_issue_pkg::rob_idx_t             redirect_rob
);

    logic [load_issue_pkg::BANKS-1:0] bank_reply;

    load_bank_if bank_io [load_issue_pkg::BANKS] ();

    //////////////////////////////////////////////////////////////////////
    // steering
    //////////////////////////////////////////////////////////////////////

    load_dispatch_steer u_steer (
        .dis_valid (dis_valid),
        .dis_data  (dis_data),
        .redirect  (redirect),
        .dis_ready (dis_ready),
        .bank_io   (bank_io)
    );

    always_comb begin
        for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
            bank_reply[b] = reply_valid && int'(reply_bank) == b;   // route to one bank
        end
    end

    //////////////////////////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < load_issue_pkg::BANKS; b++) begin : g_bank
        load_issue_bank u_bank (
            .clk           (clk),
            .rst_n         (rst_n),
            .io            (bank_io[b]),
            .wb_valid      (wb_valid),
            .wb_preg       (wb_preg),
            .reply_valid   (bank_reply[b]),
            .reply_slot    (reply_slot),
            .reply_kind    (reply_kind),
            .redirect      (redirect),
            .redirect_rob  (redirect_rob),
            .issue_ready   (issue_ready[b]),
            .issue_valid   (issue_valid[b]),
            .issue_payload (issue_payload[b]),
            .issue_rob     (issue_rob[b]),
            .issue_slot    (issue_slot[b])
        );
    end

endmodule

// File: tests/tb_load_issue_queue.sv
module tb_load_issue_queue;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUN_CYCLES   = 3000;
    localparam int DRAIN_CYCLES = 300;

    logic                                  clk;
    logic                                  rst_n;
    logic [load_issue_pkg::DIS_PORTS-1:0]  dis_valid;
    load_issue_pkg::load_dispatch_t        dis_data [load_issue_pkg::DIS_PORTS];
    logic                                  dis_ready;
    logic [load_issue_pkg::BANKS-1:0]      issue_valid;
    logic [load_issue_pkg::BANKS-1:0]      issue_ready;
    load_issue_pkg::load_payload_t         issue_payload [load_issue_pkg::BANKS];
    load_issue_pkg::rob_idx_t              issue_rob [load_issue_pkg::BANKS];
    logic [load_issue_pkg::SLOT_W-1:0]     issue_slot [load_issue_pkg::BANKS];
    logic                                  reply_valid;
    logic [load_issue_pkg::BANK_W-1:0]     reply_bank;
    logic [load_issue_pkg::SLOT_W-1:0]     reply_slot;
    load_issue_pkg::reply_kind_e           reply_kind;
    logic [load_issue_pkg::WB_PORTS-1:0]   wb_valid;
    logic [load_issue_pkg::PREG_W-1:0]     wb_preg [load_issue_pkg::WB_PORTS];
    logic                                  redirect;
    load_issue_pkg::rob_idx_t              redirect_rob;

    // predicted bank contents
    logic                           m_valid  [load_issue_pkg::BANKS][load_issue_pkg::BANK_SIZE];
    logic                           m_issued [load_issue_pkg::BANKS][load_issue_pkg::BANK_SIZE];
    load_issue_pkg::load_dispatch_t m_entry  [load_issue_pkg::BANKS][load_issue_pkg::BANK_SIZE];
    logic [load_issue_pkg::ROB_W:0] next_rob;                 // rob of the next dispatched load
    int                             n_issue;
    int                             n_replay;

    load_issue_queue i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .dis_valid     (dis_valid),
        .dis_data      (dis_data),
        .dis_ready     (dis_ready),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_payload (issue_payload),
        .issue_rob     (issue_rob),
        .issue_slot    (issue_slot),
        .reply_valid   (reply_valid),
        .reply_bank    (reply_bank),
        .reply_slot    (reply_slot),
        .reply_kind    (reply_kind),
        .wb_valid      (wb_valid),
        .wb_preg       (wb_preg),
        .redirect      (redirect),
        .redirect_rob  (redirect_rob)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_payload(string name, load_issue_pkg::load_payload_t exp,
                                 load_issue_pkg::load_payload_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_rob(string name, load_issue_pkg::rob_idx_t exp,
                             load_issue_pkg::rob_idx_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_slot(string name, logic [load_issue_pkg::SLOT_W-1:0] exp,
                              logic [load_issue_pkg::SLOT_W-1:0] act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %0d got %0d", $time, name, exp, act);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////////////////////////////////

    // distance on the 6-bit rob counter from a forward to b
    function automatic int rob_gap(logic [load_issue_pkg::ROB_W:0] a,
                                   logic [load_issue_pkg::ROB_W:0] b);
        logic [load_issue_pkg::ROB_W:0] d;
        d = b - a;
        return int'(d);
    endfunction

    function automatic logic is_older(load_issue_pkg::rob_idx_t a, load_issue_pkg::rob_idx_t b);
        int g;
        g = rob_gap(a, b);
        return g > 0 && g < (1 << load_issue_pkg::ROB_W);
    endfunction

    function automatic int bank_count(int b);
        int n;
        n = 0;
        for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
            n += m_valid[b][s];
        end
        return n;
    endfunction

    function automatic int model_occupancy();
        return bank_count(0) + bank_count(1);
    endfunction

    // k-th least occupied bank, ties to bank 0
    function automatic int ranked_bank(int k);
        int first;
        first = (bank_count(1) < bank_count(0)) ? 1 : 0;
        return (k == 0) ? first : 1 - first;
    endfunction

    function automatic int lowest_free(int b);
        int f;
        f = -1;
        for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
            if (!m_valid[b][s] && f < 0) begin
                f = s;
            end
        end
        return f;
    endfunction

    // oldest ready, unissued entry of bank b
    function automatic logic exp_issue(input int b, output load_issue_pkg::load_payload_t pl,
                                       output load_issue_pkg::rob_idx_t rob,
                                       output logic [load_issue_pkg::SLOT_W-1:0] slot);
        logic found;
        found = 1'b0;
        pl    = '0;
        rob   = '0;
        slot  = '0;
        for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
            if (m_valid[b][s] && m_entry[b][s].status.rs1_ready && !m_issued[b][s]) begin
                if (!found || is_older(m_entry[b][s].status.rob, rob)) begin
                    found = 1'b1;
                    pl    = m_entry[b][s].payload;
                    rob   = m_entry[b][s].status.rob;
                    slot  = s[load_issue_pkg::SLOT_W-1:0];
                end
            end
        end
        return found;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // compare outputs, then step the model to the next edge
    ////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : compare_outputs
        int                                tgt        [load_issue_pkg::DIS_PORTS];
        int                                alloc_slot [load_issue_pkg::DIS_PORTS];
        int                                n_dis;
        logic                              blocked;
        logic                              exp_ready;
        logic                              found;
        logic                              fire       [load_issue_pkg::BANKS];
        logic [load_issue_pkg::SLOT_W-1:0] fire_slot  [load_issue_pkg::BANKS];
        load_issue_pkg::load_payload_t     pl;
        load_issue_pkg::rob_idx_t          rob;
        logic [load_issue_pkg::SLOT_W-1:0] slot;
        logic [load_issue_pkg::ROB_W:0]    rr;
        if (rst_n) begin
            n_dis   = 0;
            blocked = 1'b0;
            for (int p = 0; p < load_issue_pkg::DIS_PORTS; p++) begin
                tgt[p] = -1;
                if (dis_valid[p]) begin
                    tgt[p] = ranked_bank(n_dis);
                    n_dis++;
                    blocked |= (bank_count(tgt[p]) == load_issue_pkg::BANK_SIZE);
                end
            end
            exp_ready = !redirect && !blocked;
            check_flag("dis_ready", exp_ready, dis_ready);

            for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
                found = exp_issue(b, pl, rob, slot) && !redirect;
                check_flag($sformatf("issue_valid[%0d]", b), found, issue_valid[b]);
                fire[b]      = found && issue_ready[b];
                fire_slot[b] = slot;
                if (found) begin
                    check_payload($sformatf("issue_payload[%0d]", b), pl, issue_payload[b]);
                    check_rob($sformatf("issue_rob[%0d]", b), rob, issue_rob[b]);
                    check_slot($sformatf("issue_slot[%0d]", b), slot, issue_slot[b]);
                end
            end

            // free slots are taken before this edge's replies land
            for (int p = 0; p < load_issue_pkg::DIS_PORTS; p++) begin
                alloc_slot[p] = (exp_ready && tgt[p] >= 0) ? lowest_free(tgt[p]) : -1;
            end

            for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
                for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
                    for (int j = 0; j < load_issue_pkg::WB_PORTS; j++) begin
                        if (m_valid[b][s] && wb_valid[j] &&
                            wb_preg[j] == m_entry[b][s].status.rs1_preg) begin
                            m_entry[b][s].status.rs1_ready = 1'b1;
                        end
                    end
                end
                if (fire[b]) begin
                    m_issued[b][fire_slot[b]] = 1'b1;
                    n_issue++;
                end
            end

            if (reply_valid && reply_kind == load_issue_pkg::reply_replay) begin
                m_issued[reply_bank][reply_slot] = 1'b0;
                n_replay++;
            end else if (reply_valid) begin
                m_valid[reply_bank][reply_slot] = 1'b0;
            end

            if (redirect) begin
                for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
                    for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
                        if (is_older(redirect_rob, m_entry[b][s].status.rob)) begin
                            m_valid[b][s] = 1'b0;
                        end
                    end
                end
                rr       = redirect_rob;
                next_rob = rr + 1'b1;                           // refetch after the redirect
            end

            for (int p = 0; p < load_issue_pkg::DIS_PORTS; p++) begin
                if (alloc_slot[p] >= 0) begin
                    m_valid[tgt[p]][alloc_slot[p]]  = 1'b1;
                    m_issued[tgt[p]][alloc_slot[p]] = 1'b0;
                    m_entry[tgt[p]][alloc_slot[p]]  = dis_data[p];
                end
            end
            if (exp_ready) begin
                next_rob = next_rob + n_dis;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////

    task automatic drive_inputs(input logic drain);
        load_issue_pkg::load_dispatch_t    d;
        int                                n;
        int                                k;
        logic                              v;
        logic                              throttle;
        logic [load_issue_pkg::PREG_W-1:0] pend [$];
        logic [load_issue_pkg::BANK_W-1:0] iss_bank [$];
        logic [load_issue_pkg::SLOT_W-1:0] iss_slot [$];
        logic [load_issue_pkg::ROB_W:0]    rr;
        throttle = drain;
        for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
            for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
                if (m_valid[b][s]) begin
                    // keep live robs well inside one lap
                    if (rob_gap(m_entry[b][s].status.rob, next_rob) >= 20) throttle = 1'b1;
                    if (!m_entry[b][s].status.rs1_ready) begin
                        pend.push_back(m_entry[b][s].status.rs1_preg);
                    end
                    if (m_issued[b][s]) begin
                        iss_bank.push_back(b[load_issue_pkg::BANK_W-1:0]);
                        iss_slot.push_back(s[load_issue_pkg::SLOT_W-1:0]);
                    end
                end
            end
        end

        n = 0;
        for (int p = 0; p < load_issue_pkg::DIS_PORTS; p++) begin
            v                   = !throttle && ($urandom_range(0, 3) != 0);
            d.status.rs1_ready  = $urandom_range(0, 1);
            d.status.rs1_preg   = $urandom;
            d.status.rob        = next_rob + n;
            d.payload.imm       = $urandom;
            d.payload.size      = load_issue_pkg::mem_size_e'($urandom_range(0, 2));
            d.payload.sext      = $urandom_range(0, 1);
            d.payload.rd        = $urandom;
            d.payload.lq_idx    = $urandom;
            d.payload.sq_idx    = $urandom;
            dis_valid[p]       <= v;
            dis_data[p]        <= d;
            n += v;
        end

        for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
            issue_ready[b] <= drain || ($urandom_range(0, 3) != 0);   // back-pressure
        end

        for (int j = 0; j < load_issue_pkg::WB_PORTS; j++) begin
            if (pend.size() > 0 && (drain || $urandom_range(0, 9) < 4)) begin
                wb_valid[j] <= 1'b1;
                wb_preg[j]  <= pend[$urandom_range(0, pend.size() - 1)];
            end else begin
                wb_valid[j] <= ($urandom_range(0, 3) == 0);
                wb_preg[j]  <= $urandom;
            end
        end

        reply_valid <= 1'b0;
        if (iss_bank.size() > 0 && (drain || $urandom_range(0, 1) == 1)) begin
            k = $urandom_range(0, iss_bank.size() - 1);
            reply_valid <= 1'b1;
            reply_bank  <= iss_bank[k];
            reply_slot  <= iss_slot[k];
            reply_kind  <= (drain || $urandom_range(0, 9) < 7) ? load_issue_pkg::reply_done
                                                                : load_issue_pkg::reply_replay;
        end

        redirect <= 1'b0;
        if (!drain && model_occupancy() > 0 && $urandom_range(0, 49) == 0) begin
            rr            = $urandom_range(1, 6);
            rr            = next_rob - rr;
            redirect     <= 1'b1;
            redirect_rob <= rr;
        end
    endtask

    initial begin
        int waited;
        void'($urandom(32'hade3ed01));
        rst_n        = 1'b0;
        dis_valid    = '0;
        issue_ready  = '0;
        reply_valid  = 1'b0;
        reply_bank   = '0;
        reply_slot   = '0;
        reply_kind   = load_issue_pkg::reply_replay;
        wb_valid     = '0;
        redirect     = 1'b0;
        redirect_rob = '0;
        for (int p = 0; p < load_issue_pkg::DIS_PORTS; p++) dis_data[p] = '0;
        for (int j = 0; j < load_issue_pkg::WB_PORTS; j++) wb_preg[j] = '0;
        for (int b = 0; b < load_issue_pkg::BANKS; b++) begin
            for (int s = 0; s < load_issue_pkg::BANK_SIZE; s++) begin
                m_valid[b][s]  = 1'b0;
                m_issued[b][s] = 1'b0;
                m_entry[b][s]  = '0;
            end
        end
        next_rob = '0;
        n_issue  = 0;
        n_replay = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk);
            drive_inputs(1'b0);
        end

        // wake, issue and retire whatever is still queued
        waited = 0;
        while (model_occupancy() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            drive_inputs(1'b1);
            waited++;
        end
        if (model_occupancy() != 0) begin
            $display("timeout: %0d loads still queued after draining", model_occupancy());
            fail_run();
        end else if (n_issue == 0 || n_replay == 0) begin
            $display("no issue or no replay was seen during the run");
            fail_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: files.f
rtl/load_issue_pkg.sv
rtl/load_bank_if.sv
rtl/load_issue_bank.sv
rtl/load_dispatch_steer.sv
rtl/load_issue_queue.sv
tests/tb_load_issue_queue.sv

// File: Bender.yml
package:
  name: load_issue_queue

sources:
  - files:
      - rtl/load_issue_pkg.sv
      - rtl/load_bank_if.sv
      - rtl/load_issue_bank.sv
      - rtl/load_dispatch_steer.sv
      - rtl/load_issue_queue.sv
  - target: test
    files:
      - tests/tb_load_issue_queue.sv
